//--- hci_queues_top.f
+incdir+tests
source/hci_queues_pkg.sv
source/hci_queue.sv
source/hci_csr.sv
source/hci_queues_top.sv
tests/tb_clk_gen.sv
tests/hci_queues_tb.sv

//--- Bender.yml
package:
  name: hci_queues

sources:
  - source/hci_queues_pkg.sv
  - source/hci_queue.sv
  - source/hci_csr.sv
  - source/hci_queues_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_clk_gen.sv
      - tests/hci_queues_tb.sv

//--- tests/hci_queues_tasks.svh
// Queue testbench tasks

task automatic stop_with_failure();
  $display("TEST FAILED");
  $fatal(1, "Simulation stopped after a failure");
endtask

task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (expected !== actual) begin
    $display("Error at %0t ns: %s, expected 0x%0h, got 0x%0h", $time, what, expected, actual);
    stop_with_failure();
  end
endtask

// Zero threshold counts as one
function automatic logic thld_reached(input int unsigned depth, input int unsigned thld);
  int unsigned level;
  level = (thld == 0) ? 1 : thld;
  return depth >= level;
endfunction

function automatic logic [31:0] status_word(input int unsigned cmd_depth,
                                            input int unsigned resp_depth);
  logic [31:0] word;
  word        = '0;
  word[3:0]   = cmd_depth[3:0];
  word[11:8]  = resp_depth[3:0];
  word[16]    = (cmd_depth == CmdFifoDepth);
  word[17]    = (cmd_depth == 0);
  word[18]    = (resp_depth == RespFifoDepth);
  word[19]    = (resp_depth == 0);
  return word;
endfunction

// One request, its acknowledge and one idle cycle
task automatic reg_access(input logic is_wr, input logic [CsrAddrWidth-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
  int unsigned waited;
  waited            = 0;
  cpuif_req.req     = 1'b1;
  cpuif_req.is_wr   = is_wr;
  cpuif_req.addr    = addr;
  cpuif_req.wr_data = wdata;
  @(posedge hclk);
  #DriveDelay;
  cpuif_req = '0;
  while (!(is_wr ? cpuif_rsp.wr_ack : cpuif_rsp.rd_ack)) begin
    if (waited == AckTimeout) begin
      $display("Register port gave no acknowledge for offset 0x%0h", addr);
      stop_with_failure();
    end else begin
      @(posedge hclk);
      #DriveDelay;
      waited++;
    end
  end
  check_value("acknowledge of the other kind", 1'b0,
              is_wr ? cpuif_rsp.rd_ack : cpuif_rsp.wr_ack);
  rdata = cpuif_rsp.rd_data;
  err   = is_wr ? cpuif_rsp.wr_err : cpuif_rsp.rd_err;
  @(posedge hclk);
  #DriveDelay;
  check_value("acknowledge longer than one cycle", 1'b0, cpuif_rsp.rd_ack | cpuif_rsp.wr_ack);
endtask

task automatic reg_write(input logic [CsrAddrWidth-1:0] addr, input logic [31:0] data,
                         input logic exp_err);
  logic [31:0] rdata;
  logic        err;
  reg_access(1'b1, addr, data, rdata, err);
  check_value($sformatf("write error flag at 0x%0h", addr), exp_err, err);
endtask

task automatic reg_read_check(input logic [CsrAddrWidth-1:0] addr, input logic [31:0] exp_data,
                              input logic exp_err);
  logic [31:0] rdata;
  logic        err;
  reg_access(1'b0, addr, '0, rdata, err);
  check_value($sformatf("read error flag at 0x%0h", addr), exp_err, err);
  check_value($sformatf("read data at 0x%0h", addr), exp_data, rdata);
endtask

task automatic cmd_write(input logic [63:0] desc, input logic exp_err);
  reg_write(CmdPortAddr, desc[31:0], 1'b0);
  reg_write(CmdPortAddr, desc[63:32], exp_err);
endtask

task automatic cmd_pop_check(input logic [63:0] exp_desc);
  int unsigned waited;
  waited = 0;
  while (!cmd_rvalid) begin
    if (waited == AckTimeout) begin
      $display("Command queue never showed a valid entry");
      stop_with_failure();
    end else begin
      @(posedge hclk);
      #DriveDelay;
      waited++;
    end
  end
  check_value("command descriptor", exp_desc, cmd_rdata);
  cmd_rready = 1'b1;
  @(posedge hclk);
  #DriveDelay;
  cmd_rready = 1'b0;
endtask

task automatic resp_push(input logic [31:0] data);
  int unsigned waited;
  waited      = 0;
  resp_wvalid = 1'b1;
  resp_wdata  = data;
  while (!resp_wready) begin
    if (waited == AckTimeout) begin
      $display("Response queue never accepted a write");
      stop_with_failure();
    end else begin
      @(posedge hclk);
      #DriveDelay;
      waited++;
    end
  end
  @(posedge hclk);
  #DriveDelay;
  resp_wvalid = 1'b0;
endtask

task automatic check_queue_status(input string name, input queue_status_t st,
                                  input int unsigned depth, input int unsigned thld,
                                  input int unsigned capacity);
  check_value({name, " depth"}, depth, st.depth);
  check_value({name, " full"}, depth == capacity, st.full);
  check_value({name, " empty"}, depth == 0, st.empty);
  check_value({name, " threshold"}, thld, st.ready_thld);
  check_value({name, " trigger"}, thld_reached(depth, thld), st.ready_thld_trig);
endtask

task automatic check_queues(input int unsigned cmd_depth, input int unsigned resp_depth,
                            input int unsigned cmd_thld, input int unsigned resp_thld);
  check_queue_status("command queue", cmd_status, cmd_depth, cmd_thld, CmdFifoDepth);
  check_queue_status("response queue", resp_status, resp_depth, resp_thld, RespFifoDepth);
  check_value("cmd_rvalid_o", cmd_depth != 0, cmd_rvalid);
  check_value("resp_wready_o", resp_depth != RespFifoDepth, resp_wready);
  reg_read_check(QueueStatusAddr, status_word(cmd_depth, resp_depth), 1'b0);
endtask

task automatic test_reset_state();
  check_value("acknowledges after reset", 2'b00, {cpuif_rsp.rd_ack, cpuif_rsp.wr_ack});
  check_queues(0, 0, 0, 0);
  reg_read_check(QueueThldAddr, 32'h0, 1'b0);
  reg_read_check(ResetCtrlAddr, 32'h0, 1'b0);
  // Unknown and write-only offsets
  reg_read_check(CmdPortAddr, 32'h0, 1'b1);
  reg_read_check(5'h14, 32'h0, 1'b1);
  reg_write(5'h1C, 32'h1234_5678, 1'b1);
endtask

task automatic test_command_order();
  logic [63:0] descs [5];
  for (int i = 0; i < 5; i++) begin
    descs[i] = {$random(seed), $random(seed)};
    cmd_write(descs[i], 1'b0);
  end
  check_queues(5, 0, 0, 0);
  // Head stays put while the controller stalls
  repeat (10) begin
    @(posedge hclk);
    #DriveDelay;
    check_value("command valid while stalled", 1'b1, cmd_rvalid);
  end
  check_value("command head while stalled", descs[0], cmd_rdata);
  for (int i = 0; i < 5; i++) begin
    cmd_pop_check(descs[i]);
    check_value("command depth after pop", 4 - i, cmd_status.depth);
  end
  check_queues(0, 0, 0, 0);
endtask

task automatic test_response_path();
  logic [31:0] resps [3];
  for (int i = 0; i < 3; i++) begin
    resps[i] = $random(seed);
    resp_push(resps[i]);
  end
  check_queues(0, 3, 0, 0);
  for (int i = 0; i < 3; i++) begin
    reg_read_check(RespPortAddr, resps[i], 1'b0);
  end
  reg_read_check(RespPortAddr, 32'h0, 1'b1);
  check_queues(0, 0, 0, 0);
endtask

task automatic test_thresholds();
  logic [63:0] descs [3];
  logic [31:0] resps [2];
  reg_write(QueueThldAddr, 32'h0000_0203, 1'b0);
  reg_read_check(QueueThldAddr, 32'h0000_0203, 1'b0);
  check_queues(0, 0, 3, 2);
  for (int i = 0; i < 3; i++) begin
    descs[i] = {$random(seed), $random(seed)};
    cmd_write(descs[i], 1'b0);
    check_queues(i + 1, 0, 3, 2);
  end
  for (int i = 0; i < 2; i++) begin
    resps[i] = $random(seed);
    resp_push(resps[i]);
    check_queues(3, i + 1, 3, 2);
  end
  // Triggers drop again while draining
  for (int i = 0; i < 3; i++) begin
    cmd_pop_check(descs[i]);
    check_queues(2 - i, 2, 3, 2);
  end
  for (int i = 0; i < 2; i++) begin
    reg_read_check(RespPortAddr, resps[i], 1'b0);
    check_queues(0, 1 - i, 3, 2);
  end
  reg_write(QueueThldAddr, 32'h0, 1'b0);
  check_queues(0, 0, 0, 0);
endtask

task automatic test_full();
  logic [63:0] descs [8];
  logic [31:0] resps [8];
  for (int i = 0; i < 8; i++) begin
    resps[i] = $random(seed);
    resp_push(resps[i]);
  end
  check_queues(0, 8, 0, 0);
  for (int i = 0; i < 8; i++) begin
    descs[i] = {$random(seed), $random(seed)};
    cmd_write(descs[i], 1'b0);
  end
  check_queues(8, 8, 0, 0);
  // Ninth descriptor is refused and dropped
  cmd_write({$random(seed), $random(seed)}, 1'b1);
  check_queues(8, 8, 0, 0);
  for (int i = 0; i < 8; i++) begin
    cmd_pop_check(descs[i]);
  end
  for (int i = 0; i < 8; i++) begin
    reg_read_check(RespPortAddr, resps[i], 1'b0);
  end
  check_queues(0, 0, 0, 0);
endtask

task automatic test_flush();
  logic [63:0] desc;
  for (int i = 0; i < 3; i++) begin
    cmd_write({$random(seed), $random(seed)}, 1'b0);
  end
  for (int i = 0; i < 2; i++) begin
    resp_push($random(seed));
  end
  // Lone low word leaves the toggle at high
  reg_write(CmdPortAddr, $random(seed), 1'b0);
  check_queues(3, 2, 0, 0);
  reg_write(ResetCtrlAddr, 32'h0000_0006, 1'b0);
  check_queues(0, 0, 0, 0);
  desc = {$random(seed), $random(seed)};
  cmd_write(desc, 1'b0);
  check_queues(1, 0, 0, 0);
  cmd_pop_check(desc);
  check_queues(0, 0, 0, 0);
endtask

//--- tests/hci_queues_tb.sv
// HCI queue pair testbench
`timescale 1ns/1ps

module hci_queues_tb
  import hci_queues_pkg::*;
();

  localparam realtime     ClkPeriod      = 40.0;
  localparam realtime     DriveDelay     = 2.0;
  localparam int unsigned ResetCycles    = 16;
  localparam int unsigned AckTimeout     = 20;
  // Roughly the length of all directed tests plus margin
  localparam int unsigned TestCycles     = 500;
  localparam int unsigned WatchdogCycles = 4 * TestCycles;

  logic                     hclk;
  logic                     reset_i;
  cpuif_req_t               cpuif_req;
  cpuif_rsp_t               cpuif_rsp;
  queue_status_t            cmd_status;
  queue_status_t            resp_status;
  logic                     cmd_rvalid;
  logic                     cmd_rready;
  logic [CmdDataWidth-1:0]  cmd_rdata;
  logic                     resp_wvalid;
  logic                     resp_wready;
  logic [RespDataWidth-1:0] resp_wdata;
  integer                   seed = 32'h2afd_d1d4;

  tb_clk_gen #(
    .Period (ClkPeriod)
  ) clk_gen (
    .clk_o (hclk)
  );

  hci_queues_top DUT (
    .hclk          (hclk),
    .reset_i       (reset_i),
    .cpuif_req_i   (cpuif_req),
    .cpuif_rsp_o   (cpuif_rsp),
    .cmd_status_o  (cmd_status),
    .cmd_rvalid_o  (cmd_rvalid),
    .cmd_rready_i  (cmd_rready),
    .cmd_rdata_o   (cmd_rdata),
    .resp_status_o (resp_status),
    .resp_wvalid_i (resp_wvalid),
    .resp_wready_o (resp_wready),
    .resp_wdata_i  (resp_wdata)
  );

  `include "hci_queues_tasks.svh"

  initial begin
    cpuif_req   = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    reset_i     = 1'b1;
    repeat (ResetCycles) @(posedge hclk);
    #DriveDelay;
    reset_i = 1'b0;

    test_reset_state();
    test_command_order();
    test_response_path();
    test_thresholds();
    test_full();
    test_flush();

    $display("TEST OK");
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: tests did not finish within %0d clock periods", WatchdogCycles);
    stop_with_failure();
  end

endmodule

//--- tests/tb_clk_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime Period = 40.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

endmodule

//--- source/hci_queues_top.sv
// HCI command and response queues
`timescale 1ns/1ps

module hci_queues_top
  import hci_queues_pkg::*;
(
  input  logic                     hclk,
  input  logic                     reset_i,

  // Software register port
  input  cpuif_req_t               cpuif_req_i,
  output cpuif_rsp_t               cpuif_rsp_o,

  // Command queue read by the controller
  output queue_status_t            cmd_status_o,
  output logic                     cmd_rvalid_o,
  input  logic                     cmd_rready_i,
  output logic [CmdDataWidth-1:0]  cmd_rdata_o,

  // Response queue written by the controller
  output queue_status_t            resp_status_o,
  input  logic                     resp_wvalid_i,
  output logic                     resp_wready_o,
  input  logic [RespDataWidth-1:0] resp_wdata_i
);

  queue_status_t            cmd_status;
  queue_status_t            resp_status;
  logic                     cmd_push;
  logic [CmdDataWidth-1:0]  cmd_push_data;
  logic [ThldWidth-1:0]     cmd_thld;
  logic                     cmd_flush;
  logic                     resp_pop;
  logic [RespDataWidth-1:0] resp_head;
  logic [ThldWidth-1:0]     resp_thld;
  logic                     resp_flush;

  hci_csr csr (
    .hclk            (hclk),
    .reset_i         (reset_i),
    .cpuif_req_i     (cpuif_req_i),
    .cpuif_rsp_o     (cpuif_rsp_o),
    .cmd_status_i    (cmd_status),
    .cmd_push_o      (cmd_push),
    .cmd_push_data_o (cmd_push_data),
    .cmd_thld_o      (cmd_thld),
    .cmd_flush_o     (cmd_flush),
    .resp_status_i   (resp_status),
    .resp_head_i     (resp_head),
    .resp_pop_o      (resp_pop),
    .resp_thld_o     (resp_thld),
    .resp_flush_o    (resp_flush)
  );

  hci_queue #(
    .Width (CmdDataWidth),
    .Depth (CmdFifoDepth)
  ) cmd_queue (
    .hclk         (hclk),
    .reset_i      (reset_i),
    .flush_i      (cmd_flush),
    .push_i       (cmd_push),
    .push_data_i  (cmd_push_data),
    .pop_i        (cmd_rready_i),
    .head_data_o  (cmd_rdata_o),
    .ready_thld_i (cmd_thld),
    .status_o     (cmd_status)
  );

  hci_queue #(
    .Width (RespDataWidth),
    .Depth (RespFifoDepth)
  ) resp_queue (
    .hclk         (hclk),
    .reset_i      (reset_i),
    .flush_i      (resp_flush),
    .push_i       (resp_wvalid_i),
    .push_data_i  (resp_wdata_i),
    .pop_i        (resp_pop),
    .head_data_o  (resp_head),
    .ready_thld_i (resp_thld),
    .status_o     (resp_status)
  );

  assign cmd_status_o  = cmd_status;
  assign resp_status_o = resp_status;

  // Handshakes come straight from occupancy
  assign cmd_rvalid_o  = ~cmd_status.empty;
  assign resp_wready_o = ~resp_status.full;

endmodule

//--- source/hci_csr.sv
// HCI queue register block
`timescale 1ns/1ps

module hci_csr
  import hci_queues_pkg::*;
(
  input  logic                     hclk,
  input  logic                     reset_i,

  input  cpuif_req_t               cpuif_req_i,
  output cpuif_rsp_t               cpuif_rsp_o,

  // Command queue side
  input  queue_status_t            cmd_status_i,
  output logic                     cmd_push_o,
  output logic [CmdDataWidth-1:0]  cmd_push_data_o,
  output logic [ThldWidth-1:0]     cmd_thld_o,
  output logic                     cmd_flush_o,

  // Response queue side
  input  queue_status_t            resp_status_i,
  input  logic [RespDataWidth-1:0] resp_head_i,
  output logic                     resp_pop_o,
  output logic [ThldWidth-1:0]     resp_thld_o,
  output logic                     resp_flush_o
);

  logic                    wr_req;
  logic                    rd_req;
  logic                    cmd_port_wr;
  logic                    thld_wr;
  logic                    rst_ctrl_wr;

  logic                    cmd_hi_q;
  logic [CmdDataWidth-1:0] cmd_data_q;
  logic [ThldWidth-1:0]    cmd_thld_q;
  logic [ThldWidth-1:0]    resp_thld_q;

  cpuif_rsp_t              rsp_d;
  cpuif_rsp_t              rsp_q;
  logic                    cmd_push_d;
  logic                    cmd_push_q;
  logic                    resp_pop_d;
  logic                    resp_pop_q;
  logic                    cmd_flush_d;
  logic                    cmd_flush_q;
  logic                    resp_flush_d;
  logic                    resp_flush_q;

  assign wr_req = cpuif_req_i.req & cpuif_req_i.is_wr;
  assign rd_req = cpuif_req_i.req & ~cpuif_req_i.is_wr;

  assign cmd_port_wr = wr_req && (cpuif_req_i.addr == CmdPortAddr);
  assign thld_wr     = wr_req && (cpuif_req_i.addr == QueueThldAddr);
  assign rst_ctrl_wr = wr_req && (cpuif_req_i.addr == ResetCtrlAddr);

  assign cmd_flush_d  = rst_ctrl_wr & cpuif_req_i.wr_data[1];
  assign resp_flush_d = rst_ctrl_wr & cpuif_req_i.wr_data[2];

  // Decode one request for the registered ack cycle
  always_comb begin
    rsp_d        = '0;
    cmd_push_d   = 1'b0;
    resp_pop_d   = 1'b0;
    rsp_d.wr_ack = wr_req;
    rsp_d.rd_ack = rd_req;

    if (wr_req) begin
      case (cpuif_req_i.addr)
        CmdPortAddr: begin
          // High word completes the descriptor
          cmd_push_d   = cmd_hi_q & ~cmd_status_i.full;
          rsp_d.wr_err = cmd_hi_q & cmd_status_i.full;
        end
        QueueThldAddr, ResetCtrlAddr: begin
          rsp_d.wr_err = 1'b0;
        end
        default: begin
          rsp_d.wr_err = 1'b1;
        end
      endcase
    end

    if (rd_req) begin
      case (cpuif_req_i.addr)
        RespPortAddr: begin
          if (resp_status_i.empty) begin
            rsp_d.rd_err = 1'b1;
          end else begin
            rsp_d.rd_data = resp_head_i;
            resp_pop_d    = 1'b1;
          end
        end
        QueueThldAddr: begin
          rsp_d.rd_data = {{(CsrDataWidth - 2 * ThldWidth){1'b0}}, resp_thld_q, cmd_thld_q};
        end
        QueueStatusAddr: begin
          rsp_d.rd_data[DepthWidth-1:0]  = cmd_status_i.depth;
          rsp_d.rd_data[8 +: DepthWidth] = resp_status_i.depth;
          rsp_d.rd_data[16]              = cmd_status_i.full;
          rsp_d.rd_data[17]              = cmd_status_i.empty;
          rsp_d.rd_data[18]              = resp_status_i.full;
          rsp_d.rd_data[19]              = resp_status_i.empty;
        end
        ResetCtrlAddr: begin
          rsp_d.rd_data = '0;
        end
        // Command port is write only
        default: begin
          rsp_d.rd_err = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      rsp_q        <= '0;
      cmd_push_q   <= 1'b0;
      resp_pop_q   <= 1'b0;
      cmd_flush_q  <= 1'b0;
      resp_flush_q <= 1'b0;
    end else begin
      rsp_q        <= rsp_d;
      cmd_push_q   <= cmd_push_d;
      resp_pop_q   <= resp_pop_d;
      cmd_flush_q  <= cmd_flush_d;
      resp_flush_q <= resp_flush_d;
    end
  end

  // Low/high word toggle returns to low after a high write or a flush
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      cmd_hi_q <= 1'b0;
    end else if (cmd_flush_d) begin
      cmd_hi_q <= 1'b0;
    end else if (cmd_port_wr) begin
      cmd_hi_q <= ~cmd_hi_q;
    end
  end

  always_ff @(posedge hclk) begin
    if (cmd_port_wr) begin
      if (cmd_hi_q) begin
        cmd_data_q[CmdDataWidth-1:CsrDataWidth] <= cpuif_req_i.wr_data;
      end else begin
        cmd_data_q[CsrDataWidth-1:0] <= cpuif_req_i.wr_data;
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
    end else if (thld_wr) begin
      cmd_thld_q  <= cpuif_req_i.wr_data[ThldWidth-1:0];
      resp_thld_q <= cpuif_req_i.wr_data[ThldWidth +: ThldWidth];
    end
  end

  assign cpuif_rsp_o     = rsp_q;
  assign cmd_push_o      = cmd_push_q;
  assign cmd_push_data_o = cmd_data_q;
  assign cmd_thld_o      = cmd_thld_q;
  assign cmd_flush_o     = cmd_flush_q;
  assign resp_pop_o      = resp_pop_q;
  assign resp_thld_o     = resp_thld_q;
  assign resp_flush_o    = resp_flush_q;

endmodule

//--- source/hci_queue.sv
// Descriptor FIFO with threshold
`timescale 1ns/1ps

module hci_queue
  import hci_queues_pkg::*;
#(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 8
) (
  input  logic                 hclk,
  input  logic                 reset_i,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  logic [Width-1:0]     push_data_i,
  input  logic                 pop_i,
  output logic [Width-1:0]     head_data_o,
  input  logic [ThldWidth-1:0] ready_thld_i,
  output queue_status_t        status_o
);

  logic [Width-1:0]           mem [Depth];
  logic [$clog2(Depth)-1:0]   wr_ptr;
  logic [$clog2(Depth)-1:0]   rd_ptr;
  logic [DepthWidth-1:0]      count;
  logic                       full;
  logic                       empty;
  logic                       do_push;
  logic                       do_pop;
  logic [ThldWidth-1:0]       eff_thld;

  assign full  = (count == DepthWidth'(Depth));
  assign empty = (count == '0);

  // Overflow and underflow requests are dropped here
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge hclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  assign head_data_o = mem[rd_ptr];

  // Zero threshold behaves as one
  assign eff_thld = (ready_thld_i == '0) ? ThldWidth'(1) : ready_thld_i;

  always_comb begin
    status_o                 = '0;
    status_o.full            = full;
    status_o.empty           = empty;
    status_o.depth           = count;
    status_o.ready_thld      = ready_thld_i;
    status_o.ready_thld_trig = (ThldWidth'(count) >= eff_thld);
  end

endmodule

//--- source/hci_queues_pkg.sv
// HCI queue pair definitions
package hci_queues_pkg;

  // Register port
  localparam int unsigned CsrAddrWidth = 5;
  localparam int unsigned CsrDataWidth = 32;

  // Descriptor widths
  localparam int unsigned CmdDataWidth  = 64;
  localparam int unsigned RespDataWidth = 32;

  // Queue sizing
  localparam int unsigned CmdFifoDepth  = 8;
  localparam int unsigned RespFifoDepth = 8;
  localparam int unsigned DepthWidth    = 4;
  localparam int unsigned ThldWidth     = 8;

  // Register byte offsets
  localparam logic [CsrAddrWidth-1:0] CmdPortAddr     = 5'h00;
  localparam logic [CsrAddrWidth-1:0] RespPortAddr    = 5'h04;
  localparam logic [CsrAddrWidth-1:0] QueueThldAddr   = 5'h08;
  localparam logic [CsrAddrWidth-1:0] QueueStatusAddr = 5'h0C;
  localparam logic [CsrAddrWidth-1:0] ResetCtrlAddr   = 5'h10;

  typedef struct packed {
    logic                    req;
    logic                    is_wr;
    logic [CsrAddrWidth-1:0] addr;
    logic [CsrDataWidth-1:0] wr_data;
  } cpuif_req_t;

  typedef struct packed {
    logic                    rd_ack;
    logic                    rd_err;
    logic [CsrDataWidth-1:0] rd_data;
    logic                    wr_ack;
    logic                    wr_err;
  } cpuif_rsp_t;

  typedef struct packed {
    logic                  full;
    logic                  empty;
    logic [DepthWidth-1:0] depth;
    logic [ThldWidth-1:0]  ready_thld;
    logic                  ready_thld_trig;
  } queue_status_t;

endpackage
